// File: all.f
src/navPkg.sv
src/actuatorPkg.sv
src/trackSampler.sv
src/dwellTimer.sv
src/navigator.sv
src/motorDriver.sv
src/statusLights.sv
src/lineCar.sv
tests/lineCarTb.sv

// File: Makefile
VERILATOR  = verilator
TOP        = lineCarTb
RTL_TOP    = lineCar
FILELIST   = all.f
OBJ_DIR    = obj_dir
FLAGS      = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/lineCarTb.sv
`timescale 1ns/1ps
`default_nettype none

module lineCarTb;

    localparam int PwmPeriod = 10;
    localparam int MaxGap    = 3;
    localparam int Full      = PwmPeriod;
    localparam int Half      = PwmPeriod / 2;

    // Expected {in1, in2, in3, in4} per wheel pair
    localparam logic [3:0] PinsHalt  = 4'b0000;
    localparam logic [3:0] PinsFwd   = 4'b1010;
    localparam logic [3:0] PinsLeft  = 4'b0110;
    localparam logic [3:0] PinsRight = 4'b1001;
    localparam logic [3:0] PinsBack  = 4'b0101;

    // LED bits 15 to 11
    localparam logic [4:0] CodeNone     = 5'b00000;
    localparam logic [4:0] CodeStraight = 5'b01000;
    localparam logic [4:0] CodeLeft     = 5'b10000;
    localparam logic [4:0] CodeRight    = 5'b00100;
    localparam logic [4:0] CodeStop     = 5'b11100;
    localparam logic [4:0] CodeBack     = 5'b01010;
    localparam logic [4:0] CodeFault    = 5'b11111;

    typedef struct packed {
        logic       enable;
        logic [2:0] pattern;
        int         hold;
        logic       settled;
        logic [3:0] pins;
        logic       codeCare;
        logic [4:0] code;
        logic [2:0] ledRoad;
        logic       armed;
        int         leftHigh;
        int         rightHigh;
    } rowT;

    logic        clk;
    logic        rst;
    logic        enable;
    logic        leftTrack;
    logic        midTrack;
    logic        rightTrack;
    logic [15:0] led;
    logic        in1;
    logic        in2;
    logic        in3;
    logic        in4;
    logic        leftPwm;
    logic        rightPwm;

    rowT rows[$];
    int  errors;
    int  checks;
    int  seed;

    lineCar #(
        .CountCycles   (8),
        .StopCycles    (6),
        .FlashCycles   (3),
        .LampCycles    (4),
        .PwmPeriod     (PwmPeriod),
        .RightCrossings(2)
    ) i_lineCar (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .leftTrack (leftTrack),
        .midTrack  (midTrack),
        .rightTrack(rightTrack),
        .led       (led),
        .in1       (in1),
        .in2       (in2),
        .in3       (in3),
        .in4       (in4),
        .leftPwm   (leftPwm),
        .rightPwm  (rightPwm)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic addRow(input logic en, input logic [2:0] pattern, input int hold,
                          input logic settled, input logic [3:0] pins, input logic codeCare,
                          input logic [4:0] code, input logic [2:0] ledRoad,
                          input logic armed, input int leftHigh, input int rightHigh);
        rowT r;
        r.enable    = en;
        r.pattern   = pattern;
        r.hold      = hold;
        r.settled   = settled;
        r.pins      = pins;
        r.codeCare  = codeCare;
        r.code      = code;
        r.ledRoad   = ledRoad;
        r.armed     = armed;
        r.leftHigh  = leftHigh;
        r.rightHigh = rightHigh;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        // Disabled, then start sequence and small corrections
        addRow(1'b0, 3'b010, 12, 1'b1, PinsHalt, 1'b1, CodeNone, 3'b010, 1'b1, 0, 0);
        addRow(1'b1, 3'b010, 20, 1'b1, PinsFwd, 1'b1, CodeStraight, 3'b010, 1'b1, Full, Full);
        addRow(1'b1, 3'b100, 12, 1'b1, PinsFwd, 1'b1, CodeNone, 3'b100, 1'b1, Half, Full);
        addRow(1'b1, 3'b001, 12, 1'b1, PinsFwd, 1'b1, CodeNone, 3'b001, 1'b1, Full, Half);
        // Junction, fork, pause inside STOP, then LEFT
        addRow(1'b1, 3'b111, 12, 1'b1, PinsLeft, 1'b0, CodeNone, 3'b111, 1'b0, Full, Full);
        addRow(1'b1, 3'b101, 6, 1'b0, PinsHalt, 1'b1, CodeStop, 3'b101, 1'b1, 0, 0);
        addRow(1'b1, 3'b010, 12, 1'b1, PinsLeft, 1'b1, CodeLeft, 3'b010, 1'b1, Full, Full);
        addRow(1'b1, 3'b101, 14, 1'b1, PinsRight, 1'b1, CodeRight, 3'b101, 1'b1, Full, Full);
        // Two crossings end the right turn
        addRow(1'b1, 3'b111, 12, 1'b1, PinsRight, 1'b1, CodeRight, 3'b111, 1'b1, Full, Full);
        addRow(1'b1, 3'b010, 12, 1'b1, PinsRight, 1'b1, CodeRight, 3'b010, 1'b1, Full, Full);
        addRow(1'b1, 3'b111, 14, 1'b1, PinsFwd, 1'b1, CodeStraight, 3'b111, 1'b0, Full, Full);
        // Second run into FAULT through a one-clock crossing before the fork
        addRow(1'b0, 3'b010, 12, 1'b1, PinsHalt, 1'b1, CodeNone, 3'b010, 1'b1, 0, 0);
        addRow(1'b1, 3'b010, 20, 1'b1, PinsFwd, 1'b1, CodeStraight, 3'b010, 1'b1, Full, Full);
        addRow(1'b1, 3'b111, 12, 1'b1, PinsLeft, 1'b0, CodeNone, 3'b111, 1'b0, Full, Full);
        addRow(1'b1, 3'b101, 24, 1'b1, PinsRight, 1'b1, CodeRight, 3'b101, 1'b1, Full, Full);
        addRow(1'b1, 3'b111, 12, 1'b1, PinsRight, 1'b1, CodeRight, 3'b111, 1'b1, Full, Full);
        addRow(1'b1, 3'b010, 12, 1'b1, PinsRight, 1'b1, CodeRight, 3'b010, 1'b1, Full, Full);
        addRow(1'b1, 3'b111, 0, 1'b0, PinsRight, 1'b1, CodeRight, 3'b010, 1'b1, 0, 0);
        addRow(1'b1, 3'b101, 12, 1'b1, PinsHalt, 1'b1, CodeFault, 3'b101, 1'b1, 0, 0);
        addRow(1'b1, 3'b010, 12, 1'b1, PinsHalt, 1'b1, CodeFault, 3'b010, 1'b1, 0, 0);
        addRow(1'b0, 3'b010, 12, 1'b1, PinsHalt, 1'b1, CodeNone, 3'b010, 1'b1, 0, 0);
        // Lost line twice for the left branch and then the right branch
        addRow(1'b1, 3'b010, 20, 1'b1, PinsFwd, 1'b1, CodeStraight, 3'b010, 1'b1, Full, Full);
        addRow(1'b1, 3'b000, 16, 1'b1, PinsBack, 1'b1, CodeBack, 3'b000, 1'b1, Full, Full);
        addRow(1'b1, 3'b111, 16, 1'b1, PinsLeft, 1'b1, CodeLeft, 3'b111, 1'b0, Full, Full);
        addRow(1'b1, 3'b010, 12, 1'b1, PinsLeft, 1'b1, CodeLeft, 3'b010, 1'b1, Full, Full);
        addRow(1'b1, 3'b111, 14, 1'b1, PinsFwd, 1'b1, CodeStraight, 3'b111, 1'b0, Full, Full);
        addRow(1'b1, 3'b000, 16, 1'b1, PinsBack, 1'b1, CodeBack, 3'b000, 1'b1, Full, Full);
        addRow(1'b1, 3'b111, 16, 1'b1, PinsRight, 1'b1, CodeRight, 3'b111, 1'b0, Full, Full);
        addRow(1'b0, 3'b000, 12, 1'b1, PinsHalt, 1'b1, CodeNone, 3'b000, 1'b1, 0, 0);
    endtask

    // Activity bits 9 to 4 shown in each steady state
    function automatic logic [5:0] activityFor(input logic [4:0] code);
        case (code)
            CodeStop:     return 6'b111111;
            CodeStraight: return 6'b001100;
            CodeLeft:     return 6'b110000;
            CodeRight:    return 6'b000011;
            default:      return 6'b000000;
        endcase
    endfunction

    task automatic checkOutputs(input int idx, input rowT r);
        checks++;
        assert ({in1, in2, in3, in4} == r.pins) else begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d IN pins %b, expected %b",
                     $time, idx, {in1, in2, in3, in4}, r.pins);
        end
        if (r.codeCare) begin
            checks++;
            assert (led[15:11] == r.code) else begin
                errors++;
                $display("CHECK FAILED at %0t: row %0d LED code %b, expected %b",
                         $time, idx, led[15:11], r.code);
            end
        end
        checks++;
        assert (led[10] == r.armed) else begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d LED armed %b, expected %b",
                     $time, idx, led[10], r.armed);
        end
        // BACK flashes its activity bits
        if (r.code != CodeBack) begin
            checks++;
            assert (led[9:3] == {activityFor(r.code), 1'b0}) else begin
                errors++;
                $display("CHECK FAILED at %0t: row %0d LED activity %b, expected %b",
                         $time, idx, led[9:3], {activityFor(r.code), 1'b0});
            end
        end
        checks++;
        assert (led[2:0] == r.ledRoad) else begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d LED road %b, expected %b",
                     $time, idx, led[2:0], r.ledRoad);
        end
    endtask

    // High clocks over one full PWM period give the duty
    task automatic checkPwm(input int idx, input rowT r);
        int leftCount;
        int rightCount;
        leftCount  = 0;
        rightCount = 0;
        repeat (PwmPeriod) begin
            @(negedge clk);
            if (leftPwm) begin
                leftCount++;
            end
            if (rightPwm) begin
                rightCount++;
            end
        end
        checks += 2;
        assert (leftCount == r.leftHigh) else begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d left PWM high %0d, expected %0d",
                     $time, idx, leftCount, r.leftHigh);
        end
        assert (rightCount == r.rightHigh) else begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d right PWM high %0d, expected %0d",
                     $time, idx, rightCount, r.rightHigh);
        end
    endtask

    initial begin
        int  gap;
        rowT r;
        seed       = 27793;
        errors     = 0;
        checks     = 0;
        rst        = 1'b1;
        enable     = 1'b0;
        leftTrack  = 1'b0;
        midTrack   = 1'b0;
        rightTrack = 1'b0;
        buildTable();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            @(posedge clk);
            enable                             <= r.enable;
            {leftTrack, midTrack, rightTrack} <= r.pattern;
            repeat (r.hold) @(posedge clk);
            @(negedge clk);
            checkOutputs(i, r);
            // Transient rows hand over to the next row on the following edge
            if (r.settled) begin
                checkPwm(i, r);
                gap = $unsigned($random(seed)) % (MaxGap + 1);
                repeat (gap) @(posedge clk);
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int budget;
        @(negedge rst);
        budget = 100;
        for (int i = 0; i < rows.size(); i++) begin
            budget += rows[i].hold + PwmPeriod + MaxGap + 2;
        end
        repeat (budget) @(posedge clk);
        $display("Run timed out after %0d cycles before the table was finished", budget);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/lineCar.sv
`timescale 1ns/1ps
`default_nettype none

module lineCar #(
    parameter int CountCycles    = 150000000,
    parameter int StopCycles     = 50000000,
    parameter int FlashCycles    = 12500000,
    parameter int LampCycles     = 30000000,
    parameter int PwmPeriod      = 255,
    parameter int RightCrossings = 2
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            enable,
    input  wire logic            leftTrack,
    input  wire logic            midTrack,
    input  wire logic            rightTrack,
    output actuatorPkg::ledWordT led,
    output logic                 in1,
    output logic                 in2,
    output logic                 in3,
    output logic                 in4,
    output logic                 leftPwm,
    output logic                 rightPwm
);
    import navPkg::*;

    roadT     road;
    navStateT state;
    logic     armed;

    trackSampler sampler (
        .clk       (clk),
        .rst       (rst),
        .leftTrack (leftTrack),
        .midTrack  (midTrack),
        .rightTrack(rightTrack),
        .road      (road)
    );

    navigator #(
        .CountCycles   (CountCycles),
        .StopCycles    (StopCycles),
        .RightCrossings(RightCrossings)
    ) nav (
        .clk   (clk),
        .rst   (rst),
        .enable(enable),
        .road  (road),
        .state (state),
        .armed (armed)
    );

    motorDriver #(.PwmPeriod(PwmPeriod)) motor (
        .clk     (clk),
        .rst     (rst),
        .state   (state),
        .in1     (in1),
        .in2     (in2),
        .in3     (in3),
        .in4     (in4),
        .leftPwm (leftPwm),
        .rightPwm(rightPwm)
    );

    statusLights #(
        .FlashCycles(FlashCycles),
        .LampCycles (LampCycles)
    ) lights (
        .clk  (clk),
        .rst  (rst),
        .state(state),
        .road (road),
        .armed(armed),
        .led  (led)
    );

endmodule

`default_nettype wire

// File: src/statusLights.sv
`timescale 1ns/1ps
`default_nettype none

module statusLights #(
    parameter int FlashCycles = 12500000,
    parameter int LampCycles  = 30000000
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire navPkg::navStateT state,
    input  wire navPkg::roadT     road,
    input  wire logic             armed,
    output actuatorPkg::ledWordT  led
);
    import navPkg::*;

    localparam int FlashW = $clog2(FlashCycles + 1);
    localparam int LampW  = $clog2(LampCycles + 1);
    localparam logic [FlashW-1:0] FlashLast = FlashW'(FlashCycles - 1);
    localparam logic [LampW-1:0]  LampLast  = LampW'(LampCycles - 1);

    logic [FlashW-1:0] flashCount;
    logic              flashOn;
    logic              flashing;
    logic [LampW-1:0]  lampCount;
    logic [2:0]        lamp;
    logic [4:0]        stateCode;
    logic [5:0]        activity;

    assign flashing = (state == COUNT) || (state == BACK);

    // Flash phase restarts lit on every entry
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flashCount <= '0;
            flashOn    <= 1'b1;
        end else if (!flashing) begin
            flashCount <= '0;
            flashOn    <= 1'b1;
        end else if (flashCount == FlashLast) begin
            flashCount <= '0;
            flashOn    <= !flashOn;
        end else begin
            flashCount <= flashCount + 1'b1;
        end
    end

    // Junction lamp walks one step per LampCycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lampCount <= '0;
            lamp      <= 3'b001;
        end else if (state != CHOOSE) begin
            lampCount <= '0;
            lamp      <= 3'b001;
        end else if (lampCount == LampLast) begin
            lampCount <= '0;
            lamp      <= {lamp[1:0], lamp[2]};
        end else begin
            lampCount <= lampCount + 1'b1;
        end
    end

    always_comb begin
        case (state)
            START:    stateCode = 5'b00001;
            COUNT:    stateCode = 5'b00010;
            STRAIGHT: stateCode = 5'b01000;
            CHOOSE:   stateCode = {lamp, 2'b00};
            LEFT:     stateCode = 5'b10000;
            RIGHT:    stateCode = 5'b00100;
            STOP:     stateCode = 5'b11100;
            BACK:     stateCode = 5'b01010;
            FAULT:    stateCode = 5'b11111;
            default:  stateCode = 5'b00000;
        endcase
        case (state)
            STOP:        activity = 6'b111111;
            COUNT, BACK: activity = flashOn ? 6'b111111 : 6'b000000;
            STRAIGHT:    activity = 6'b001100;
            LEFT:        activity = 6'b110000;
            RIGHT:       activity = 6'b000011;
            default:     activity = 6'b000000;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led <= '0;
        end else begin
            led <= {stateCode, armed, activity, 1'b0, road};
        end
    end

endmodule

`default_nettype wire

// File: src/motorDriver.sv
`timescale 1ns/1ps
`default_nettype none

module motorDriver #(
    parameter int PwmPeriod = 255
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire navPkg::navStateT state,
    output logic                  in1,
    output logic                  in2,
    output logic                  in3,
    output logic                  in4,
    output logic                  leftPwm,
    output logic                  rightPwm
);
    import navPkg::*;
    import actuatorPkg::*;

    localparam dutyT FullDuty = dutyT'(PwmPeriod);
    localparam dutyT HalfDuty = dutyT'(PwmPeriod / 2);

    dutyT     pwmCount;
    dutyT     leftDuty;
    dutyT     rightDuty;
    wheelDirT leftDir;
    wheelDirT rightDir;
    wheelDirT leftDirQ;
    wheelDirT rightDirQ;

    always_comb begin
        leftDir   = wheelHalt;
        rightDir  = wheelHalt;
        leftDuty  = '0;
        rightDuty = '0;
        case (state)
            STRAIGHT: begin
                {leftDir, rightDir}   = {wheelForward, wheelForward};
                {leftDuty, rightDuty} = {FullDuty, FullDuty};
            end
            // Slow the inner wheel to steer back onto the line
            LITTLE_LEFT: begin
                {leftDir, rightDir}   = {wheelForward, wheelForward};
                {leftDuty, rightDuty} = {HalfDuty, FullDuty};
            end
            LITTLE_RIGHT: begin
                {leftDir, rightDir}   = {wheelForward, wheelForward};
                {leftDuty, rightDuty} = {FullDuty, HalfDuty};
            end
            LEFT, CHOOSE: begin
                {leftDir, rightDir}   = {wheelReverse, wheelForward};
                {leftDuty, rightDuty} = {FullDuty, FullDuty};
            end
            RIGHT: begin
                {leftDir, rightDir}   = {wheelForward, wheelReverse};
                {leftDuty, rightDuty} = {FullDuty, FullDuty};
            end
            BACK: begin
                {leftDir, rightDir}   = {wheelReverse, wheelReverse};
                {leftDuty, rightDuty} = {FullDuty, FullDuty};
            end
            default: ;
        endcase
    end

    // Free-running PWM period counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pwmCount <= '0;
        end else if (pwmCount >= FullDuty - dutyT'(1)) begin
            pwmCount <= '0;
        end else begin
            pwmCount <= pwmCount + dutyT'(1);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            leftDirQ  <= wheelHalt;
            rightDirQ <= wheelHalt;
            leftPwm   <= 1'b0;
            rightPwm  <= 1'b0;
        end else begin
            leftDirQ  <= leftDir;
            rightDirQ <= rightDir;
            leftPwm   <= (pwmCount < leftDuty);
            rightPwm  <= (pwmCount < rightDuty);
        end
    end

    assign in1 = leftDirQ[1];
    assign in2 = leftDirQ[0];
    assign in3 = rightDirQ[1];
    assign in4 = rightDirQ[0];

endmodule

`default_nettype wire

// File: src/navigator.sv
`timescale 1ns/1ps
`default_nettype none

module navigator #(
    parameter int CountCycles    = 150000000,
    parameter int StopCycles     = 50000000,
    parameter int RightCrossings = 2
) (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         enable,
    input  wire navPkg::roadT road,
    output navPkg::navStateT  state,
    output logic              armed
);
    import navPkg::*;

    localparam int CrossW = $clog2(RightCrossings + 1);
    localparam logic [CrossW-1:0] CrossLimit = CrossW'(RightCrossings);

    navStateT          nextState;
    navStateT          resumeState;
    navStateT          nextResume;
    logic              branchTaken;
    logic              setBranch;
    logic [CrossW-1:0] crossCount;
    logic              crossSeen;
    logic              crossRise;
    logic              crossesDone;
    logic              countRun;
    logic              countDone;
    logic              stopRun;
    logic              stopDone;

    assign countRun    = (state == COUNT);
    assign stopRun     = (state == STOP);
    assign crossRise   = (road == roadCross) && !crossSeen;
    assign crossesDone = (crossCount >= CrossLimit);

    dwellTimer #(.Cycles(CountCycles)) countTimer (
        .clk (clk),
        .rst (rst),
        .run (countRun),
        .done(countDone)
    );

    dwellTimer #(.Cycles(StopCycles)) stopTimer (
        .clk (clk),
        .rst (rst),
        .run (stopRun),
        .done(stopDone)
    );

    always_comb begin
        nextState  = state;
        nextResume = resumeState;
        setBranch  = 1'b0;
        if (!enable) begin
            nextState = IDLE;
        end else begin
            case (state)
                IDLE:  nextState = START;
                START: nextState = (road == roadStraight) ? COUNT : START;
                COUNT: nextState = countDone ? STRAIGHT : COUNT;
                STRAIGHT, LITTLE_LEFT, LITTLE_RIGHT: begin
                    case (road)
                        roadLost: begin
                            nextState  = STOP;
                            nextResume = BACK;
                        end
                        // Crossing seen on entry must not count as a junction
                        roadCross:       nextState = armed ? CHOOSE : state;
                        roadLittleRight: nextState = LITTLE_RIGHT;
                        roadLittleLeft:  nextState = LITTLE_LEFT;
                        default:         nextState = STRAIGHT;
                    endcase
                end
                CHOOSE: begin
                    if (road == roadFork) begin
                        nextState  = STOP;
                        nextResume = LEFT;
                    end else if (road == roadCross && armed) begin
                        nextState = STRAIGHT;
                    end
                end
                LEFT: begin
                    if (armed && road == roadCross) begin
                        nextState  = STOP;
                        nextResume = STRAIGHT;
                    end else if (armed && road == roadFork) begin
                        nextState  = STOP;
                        nextResume = RIGHT;
                    end
                end
                RIGHT: begin
                    if (crossesDone && road == roadCross) begin
                        nextState  = STOP;
                        nextResume = STRAIGHT;
                    end else if (crossesDone && road == roadFork) begin
                        nextState = FAULT;
                    end
                end
                BACK: begin
                    // Left branch first, right branch on the next retreat
                    if (road == roadCross) begin
                        nextState  = STOP;
                        nextResume = branchTaken ? RIGHT : LEFT;
                        setBranch  = !branchTaken;
                    end
                end
                STOP:    nextState = stopDone ? resumeState : STOP;
                FAULT:   nextState = FAULT;
                default: nextState = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            resumeState <= IDLE;
            branchTaken <= 1'b0;
        end else begin
            state       <= nextState;
            resumeState <= nextResume;
            if (state == IDLE || state == CHOOSE) begin
                branchTaken <= 1'b0;
            end else if (setBranch) begin
                branchTaken <= 1'b1;
            end
        end
    end

    // Checkpoint flag and right-turn crossing count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed      <= 1'b0;
            crossSeen  <= 1'b0;
            crossCount <= '0;
        end else begin
            crossSeen <= (road == roadCross);
            if (nextState != state) begin
                armed <= (state == COUNT) && (nextState == STRAIGHT);
            end else if (road != roadCross) begin
                armed <= 1'b1;
            end
            if (state != RIGHT) begin
                crossCount <= '0;
            end else if (armed && crossRise && !crossesDone) begin
                crossCount <= crossCount + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/dwellTimer.sv
`timescale 1ns/1ps
`default_nettype none

module dwellTimer #(
    parameter int Cycles = 1000
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic run,
    output logic      done
);
    localparam int CountW = $clog2(Cycles + 1);
    localparam logic [CountW-1:0] Limit = CountW'(Cycles);

    logic [CountW-1:0] count;

    // Saturates at the limit so done holds while run stays high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (count != Limit) begin
            count <= count + 1'b1;
        end
    end

    assign done = run && (count == Limit);

endmodule

`default_nettype wire

// File: src/trackSampler.sv
`timescale 1ns/1ps
`default_nettype none

module trackSampler (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         leftTrack,
    input  wire logic         midTrack,
    input  wire logic         rightTrack,
    output navPkg::roadT      road
);
    import navPkg::*;

    // First synchronizer stage holding the packed pattern
    roadT syncStage;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            syncStage <= roadLost;
            road      <= roadLost;
        end else begin
            syncStage <= {leftTrack, midTrack, rightTrack};
            road      <= syncStage;
        end
    end

endmodule

`default_nettype wire

// File: src/actuatorPkg.sv
`default_nettype none

package actuatorPkg;

    // Encoded as the IN pin pair of one wheel
    typedef enum logic [1:0] {
        wheelHalt    = 2'b00,
        wheelReverse = 2'b01,
        wheelForward = 2'b10
    } wheelDirT;

    // PWM compare value
    typedef logic [7:0] dutyT;

    typedef logic [15:0] ledWordT;

endpackage

`default_nettype wire

// File: src/navPkg.sv
`default_nettype none

package navPkg;

    // Sensor pattern with the left sensor in the MSB
    typedef logic [2:0] roadT;

    localparam roadT roadLost        = 3'b000;
    localparam roadT roadLittleRight = 3'b001;
    localparam roadT roadStraight    = 3'b010;
    localparam roadT roadRight       = 3'b011;
    localparam roadT roadLittleLeft  = 3'b100;
    localparam roadT roadFork        = 3'b101;
    localparam roadT roadLeft        = 3'b110;
    localparam roadT roadCross       = 3'b111;

    // Course states
    typedef enum logic [3:0] {
        IDLE,
        START,
        COUNT,
        STRAIGHT,
        LITTLE_LEFT,
        LITTLE_RIGHT,
        CHOOSE,
        LEFT,
        RIGHT,
        BACK,
        STOP,
        FAULT
    } navStateT;

endpackage

`default_nettype wire
